// File: doe.f
+incdir+include
hw/doe_pkg.sv
hw/doe_if.sv
hw/doe_cmd_reg.sv
hw/doe_fsm.sv
hw/doe_cipher.sv
hw/key_vault.sv
hw/doe_top.sv
dv/doe_sva.sv
dv/doe_checker.sv
dv/doe_tb.sv

// File: Makefile
# Verilator build, run and lint for the deobfuscation engine

.PHONY: all run lint clean

all: run

obj_dir/Vdoe_tb: doe.f $(wildcard hw/*.sv dv/*.sv include/*.svh)
	verilator --binary --timing --assert -f doe.f --top-module doe_tb -o Vdoe_tb

run: obj_dir/Vdoe_tb
	./obj_dir/Vdoe_tb +verilator+error+limit+100 > sim.log 2>&1 || \
		echo "Checks failed: simulator exited with an error" >> sim.log
	@cat sim.log
	@if grep -q "Checks failed" sim.log; then echo "simulation failed"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f doe.f --top-module doe_tb

clean:
	rm -rf obj_dir sim.log

// File: dv/doe_tb.sv
/* deobfuscation engine testbench
   random flows, zeroize and both resets, checked by the model in doe_checker */
`timescale 1ns/1ns

module doe_tb;
    import doe_pkg::*;

    localparam logic [127:0] ROOT_KEY = 128'h5a3c96e1_0f872d4b_c1e07a39_6b2d48f5;
    localparam int N_ROUNDS = 5;
    localparam int SWEEP_CYCLES = KV_NUM_ENTRIES * KV_ENTRY_DWORDS;
    // a round has six sweeps and about six flows of at most 60 cycles
    localparam int ROUND_CYCLES = 6 * SWEEP_CYCLES + 400;
    localparam int TIMEOUT_CYCLES = N_ROUNDS * ROUND_CYCLES + 100;

    logic clk;
    logic rst_b;
    logic hard_rst_b;
    logic cmd_valid;
    doe_cmd_e cmd;
    logic [KV_ENTRY_ADDR_W-1:0] dest_sel;
    logic zeroize;
    logic [OBF_UDS_DWORDS*32-1:0] obf_uds_seed;
    logic [OBF_FE_DWORDS*32-1:0] obf_field_entropy;
    logic [KV_ENTRY_ADDR_W-1:0] rd_entry;
    logic [KV_OFFSET_W-1:0] rd_offset;
    logic [31:0] rd_data;
    logic flow_done;
    logic flow_in_progress;
    logic lock_uds;
    logic lock_fe;
    logic sweep_on;

    int seed;
    int cycles;
    int tb_errors;
    int reported;
    int tests;
    int expected_dones;

    doe_top #(.ROOT_KEY(ROOT_KEY)) dut_i (.*);

    doe_checker #(.ROOT_KEY(ROOT_KEY)) chk_i (.*);

    bind doe_fsm doe_sva sva_i (
        .clk(clk),
        .rst_b(rst_b),
        .init(cph.init),
        .next(cph.next),
        .write_en(write_en),
        .flow_done(flow_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [KV_ENTRY_ADDR_W-1:0] random_dest();
        return KV_ENTRY_ADDR_W'($random(seed));
    endfunction

    function automatic int all_errors();
        return tb_errors + chk_i.errors + dut_i.fsm_i.sva_i.fail_count;
    endfunction

    task automatic draw_secrets();
        for (int i = 0; i < OBF_UDS_DWORDS; i++) begin
            obf_uds_seed[i*32 +: 32] = $random(seed);
        end
        for (int i = 0; i < OBF_FE_DWORDS; i++) begin
            obf_field_entropy[i*32 +: 32] = $random(seed);
        end
    endtask

    task automatic issue_cmd(input doe_cmd_e c, input logic [KV_ENTRY_ADDR_W-1:0] d);
        cmd_valid = 1'b1;
        cmd = c;
        dest_sel = d;
        tick();
        cmd_valid = 1'b0;
        cmd = DOE_IDLE_CMD;
    endtask

    // every command waited on here owes exactly one flow_done
    task automatic wait_done();
        logic seen;
        int n;
        seen = 1'b0;
        n = 0;
        expected_dones++;
        while (!seen && n < 100) begin
            @(negedge clk);
            seen = flow_done;
            n++;
        end
        if (!seen) begin
            $display("flow_done did not arrive within 100 cycles");
            tb_errors++;
        end
        tick();
    endtask

    task automatic expect_quiet(input int n);
        int hits;
        hits = 0;
        repeat (n) begin
            @(negedge clk);
            if (flow_done) begin
                hits++;
            end
        end
        if (hits != 0) begin
            $display("flow_done pulsed %0d times after zeroize with no new command", hits);
            tb_errors++;
        end
        tick();
    endtask

    // the checker compares each address at the falling edge
    task automatic sweep();
        sweep_on = 1'b1;
        for (int e = 0; e < KV_NUM_ENTRIES; e++) begin
            for (int o = 0; o < KV_ENTRY_DWORDS; o++) begin
                rd_entry = KV_ENTRY_ADDR_W'(e);
                rd_offset = KV_OFFSET_W'(o);
                tick();
            end
        end
        sweep_on = 1'b0;
    endtask

    task automatic end_test(input int r, input string name);
        int total;
        total = all_errors();
        if (total == reported) begin
            $display("round %0d test %s: ok", r, name);
        end else begin
            $display("round %0d test %s: %0d errors", r, name, total - reported);
        end
        reported = total;
        tests++;
    endtask

    initial begin
        logic [KV_ENTRY_ADDR_W-1:0] d;
        int total;
        seed = 59;
        tb_errors = 0;
        reported = 0;
        tests = 0;
        expected_dones = 0;
        rst_b = 1'b0;
        hard_rst_b = 1'b0;
        cmd_valid = 1'b0;
        cmd = DOE_IDLE_CMD;
        dest_sel = '0;
        zeroize = 1'b0;
        obf_uds_seed = '0;
        obf_field_entropy = '0;
        rd_entry = '0;
        rd_offset = '0;
        sweep_on = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_b = 1'b1;
        hard_rst_b = 1'b1;

        for (int r = 0; r < N_ROUNDS; r++) begin
            if (r > 0) begin
                hard_rst_b = 1'b0;
                repeat (2) tick();
                hard_rst_b = 1'b1;
                tick();
                end_test(r, "hard_reset");
            end
            draw_secrets();

            // abort a flow somewhere before its last block
            issue_cmd(($random(seed) & 1) ? DOE_UDS : DOE_FE, random_dest());
            repeat (1 + ($random(seed) & 15)) tick();
            zeroize = 1'b1;
            tick();
            zeroize = 1'b0;
            sweep();
            expect_quiet(20);
            end_test(r, "zeroize");

            // a second command while the flow runs has to be dropped
            d = random_dest();
            issue_cmd(DOE_UDS, d);
            repeat (2 + ($random(seed) & 15)) tick();
            issue_cmd(DOE_FE, d + 1'b1);
            wait_done();
            sweep();
            end_test(r, "uds_flow");

            issue_cmd(DOE_FE, random_dest());
            wait_done();
            sweep();
            end_test(r, "fe_flow");

            issue_cmd(DOE_UDS, random_dest());
            wait_done();
            issue_cmd(DOE_FE, random_dest());
            wait_done();
            sweep();
            end_test(r, "locked_repeat");

            rst_b = 1'b0;
            repeat (3) tick();
            rst_b = 1'b1;
            tick();
            sweep();
            issue_cmd(DOE_UDS, random_dest());
            wait_done();
            sweep();
            end_test(r, "soft_reset");
        end

        total = all_errors();
        if (chk_i.done_count != expected_dones) begin
            $display("MISMATCH flow_done count: got %h expected %h",
                     chk_i.done_count, expected_dones);
            total++;
        end
        $display("tests %0d, errors %0d", tests, total);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: dv/doe_checker.sv
/* deobfuscation engine checker
   models commands, locks, cipher chaining and the vault, compares read data */
`timescale 1ns/1ns

module doe_checker #(
    parameter logic [127:0] ROOT_KEY = '0
) (
    input logic clk,
    input logic rst_b,
    input logic hard_rst_b,
    input logic cmd_valid,
    input doe_pkg::doe_cmd_e cmd,
    input logic [doe_pkg::KV_ENTRY_ADDR_W-1:0] dest_sel,
    input logic zeroize,
    input logic [doe_pkg::OBF_UDS_DWORDS*32-1:0] obf_uds_seed,
    input logic [doe_pkg::OBF_FE_DWORDS*32-1:0] obf_field_entropy,
    input logic [doe_pkg::KV_ENTRY_ADDR_W-1:0] rd_entry,
    input logic [doe_pkg::KV_OFFSET_W-1:0] rd_offset,
    input logic [31:0] rd_data,
    input logic flow_done,
    input logic flow_in_progress,
    input logic lock_uds,
    input logic lock_fe,
    input logic sweep_on
);
    import doe_pkg::*;

    logic [31:0] exp_vault [KV_NUM_ENTRIES][KV_ENTRY_DWORDS];
    logic exp_lock_uds;
    logic exp_lock_fe;
    doe_cmd_e held_cmd;
    logic [KV_ENTRY_ADDR_W-1:0] held_dest;
    int errors = 0;
    int done_count = 0;

    function automatic logic [127:0] rotate_left(input logic [127:0] v);
        return (v << ROUND_ROT) | (v >> (128 - ROUND_ROT));
    endfunction

    function automatic void clear_vault();
        foreach (exp_vault[e, o]) begin
            exp_vault[e][o] = '0;
        end
    endfunction

    // every block runs the full rounds under one key, then its result keys the next block
    function automatic void unwrap(input logic uds, input logic [KV_ENTRY_ADDR_W-1:0] entry);
        logic [127:0] key;
        logic [127:0] s;
        int blocks;
        key = ROOT_KEY;
        blocks = uds ? OBF_UDS_DWORDS / 4 : OBF_FE_DWORDS / 4;
        for (int b = 0; b < blocks; b++) begin
            s = uds ? obf_uds_seed[b*128 +: 128] : obf_field_entropy[b*128 +: 128];
            for (int r = 0; r < CIPHER_ROUNDS; r++) begin
                s = rotate_left(s) ^ key;
            end
            key = s;
            // most significant dword lands at the lowest offset
            for (int d = 0; d < 4; d++) begin
                exp_vault[entry][b*4 + d] = s[(3-d)*32 +: 32];
            end
        end
    endfunction

    always @(negedge clk) begin
        // outputs first, against the model as of the last rising edge
        if (hard_rst_b) begin
            if (lock_uds !== exp_lock_uds) begin
                $display("MISMATCH lock_uds: got %h expected %h", lock_uds, exp_lock_uds);
                errors++;
            end
            if (lock_fe !== exp_lock_fe) begin
                $display("MISMATCH lock_fe: got %h expected %h", lock_fe, exp_lock_fe);
                errors++;
            end
        end
        // a flow is in progress exactly while a command is held
        if (rst_b && flow_in_progress !== (held_cmd != DOE_IDLE_CMD)) begin
            $display("MISMATCH flow_in_progress: got %h expected %h",
                     flow_in_progress, held_cmd != DOE_IDLE_CMD);
            errors++;
        end
        if (sweep_on && rst_b && rd_data !== exp_vault[rd_entry][rd_offset]) begin
            $display("MISMATCH rd_data entry %h offset %h: got %h expected %h",
                     rd_entry, rd_offset, rd_data, exp_vault[rd_entry][rd_offset]);
            errors++;
        end

        // then step the model over the coming rising edge
        if (!rst_b) begin
            clear_vault();
            held_cmd = DOE_IDLE_CMD;
            held_dest = '0;
        end else begin
            if (flow_done) begin
                done_count++;
                if (held_cmd == DOE_UDS) begin
                    if (!exp_lock_uds) begin
                        unwrap(1'b1, held_dest);
                    end
                    exp_lock_uds = 1'b1;
                end else if (held_cmd == DOE_FE) begin
                    if (!exp_lock_fe) begin
                        unwrap(1'b0, held_dest);
                    end
                    exp_lock_fe = 1'b1;
                end else begin
                    $display("flow_done pulsed while no command was held");
                    errors++;
                end
            end
            if (zeroize) begin
                clear_vault();
            end
            if (flow_done || zeroize) begin
                held_cmd = DOE_IDLE_CMD;
            end else if (cmd_valid && held_cmd == DOE_IDLE_CMD) begin
                held_cmd = cmd;
                held_dest = dest_sel;
            end
        end
        if (!hard_rst_b) begin
            exp_lock_uds = 1'b0;
            exp_lock_fe = 1'b0;
        end
    end

endmodule

// File: dv/doe_sva.sv
/* deobfuscation controller assertions on the cipher and vault strobes */
`timescale 1ns/1ns

module doe_sva (
    input logic clk,
    input logic rst_b,
    input logic init,
    input logic next,
    input logic write_en,
    input logic flow_done
);
    int fail_count = 0;

    // the cipher and the vault are never strobed in the same cycle
    strobe_onehot: assert property (@(posedge clk) disable iff (!rst_b)
        $onehot0({init, next, write_en}))
        else begin
            $error("more than one of init, next and write_en is high");
            fail_count++;
        end

    done_single: assert property (@(posedge clk) disable iff (!rst_b)
        flow_done |=> !flow_done)
        else begin
            $error("flow_done high for two cycles in a row");
            fail_count++;
        end

endmodule

// File: hw/doe_top.sv
/* deobfuscation engine top
   command register, flow controller, cipher and key vault */
`timescale 1ns/1ns

module doe_top #(
    parameter int SRC_WIDTH = 128,
    parameter int DEST_WIDTH = 128,
    parameter logic [127:0] ROOT_KEY = 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0
) (
    input logic clk,
    input logic rst_b,
    input logic hard_rst_b,
    input logic cmd_valid,
    input doe_pkg::doe_cmd_e cmd,
    input logic [doe_pkg::KV_ENTRY_ADDR_W-1:0] dest_sel,
    input logic zeroize,
    input logic [doe_pkg::OBF_UDS_DWORDS*32-1:0] obf_uds_seed,
    input logic [doe_pkg::OBF_FE_DWORDS*32-1:0] obf_field_entropy,
    input logic [doe_pkg::KV_ENTRY_ADDR_W-1:0] rd_entry,
    input logic [doe_pkg::KV_OFFSET_W-1:0] rd_offset,
    output logic [31:0] rd_data,
    output logic flow_done,
    output logic flow_in_progress,
    output logic lock_uds,
    output logic lock_fe
);
    import doe_pkg::*;

    doe_cmd_e cur_cmd;
    logic [KV_ENTRY_ADDR_W-1:0] cur_dest;

    kv_write_if kv_if ();
    doe_cipher_if #(.SRC_WIDTH(SRC_WIDTH), .DEST_WIDTH(DEST_WIDTH)) cph_if ();

    doe_cmd_reg cmd_reg_i (
        .clk(clk),
        .rst_b(rst_b),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .dest_sel(dest_sel),
        .flow_done(flow_done),
        .zeroize(zeroize),
        .cur_cmd(cur_cmd),
        .cur_dest(cur_dest)
    );

    doe_fsm #(.SRC_WIDTH(SRC_WIDTH), .DEST_WIDTH(DEST_WIDTH)) fsm_i (
        .clk(clk),
        .rst_b(rst_b),
        .hard_rst_b(hard_rst_b),
        .cur_cmd(cur_cmd),
        .cur_dest(cur_dest),
        .obf_uds_seed(obf_uds_seed),
        .obf_field_entropy(obf_field_entropy),
        .zeroize(zeroize),
        .cph(cph_if.fsm),
        .kv(kv_if.fsm),
        .flow_done(flow_done),
        .flow_in_progress(flow_in_progress),
        .lock_uds(lock_uds),
        .lock_fe(lock_fe)
    );

    doe_cipher #(
        .SRC_WIDTH(SRC_WIDTH),
        .DEST_WIDTH(DEST_WIDTH),
        .ROOT_KEY(ROOT_KEY)
    ) cipher_i (
        .clk(clk),
        .rst_b(rst_b),
        .cph(cph_if.cipher)
    );

    key_vault vault_i (
        .clk(clk),
        .rst_b(rst_b),
        .kv(kv_if.vault),
        .zeroize(zeroize),
        .rd_entry(rd_entry),
        .rd_offset(rd_offset),
        .rd_data(rd_data)
    );

endmodule

// File: hw/key_vault.sv
/* key vault storage
   entries of dwords with one write port, one read port and zeroize */
`timescale 1ns/1ns

module key_vault (
    input logic clk,
    input logic rst_b,
    kv_write_if.vault kv,
    input logic zeroize,
    input logic [doe_pkg::KV_ENTRY_ADDR_W-1:0] rd_entry,
    input logic [doe_pkg::KV_OFFSET_W-1:0] rd_offset,
    output logic [31:0] rd_data
);
    import doe_pkg::*;

    logic [KV_NUM_ENTRIES-1:0][KV_ENTRY_DWORDS-1:0][31:0] mem;

    // zeroize beats a write in the same cycle
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            mem <= '0;
        end else if (zeroize) begin
            mem <= '0;
        end else if (kv.write_en) begin
            mem[kv.write_entry][kv.write_offset] <= kv.write_data;
        end
    end

    assign rd_data = mem[rd_entry][rd_offset];

endmodule

// File: hw/doe_cipher.sv
/* iterated rotate-and-xor block cipher
   each result is chained in as the key for the following block */
`timescale 1ns/1ns

module doe_cipher #(
    parameter int SRC_WIDTH = 128,
    parameter int DEST_WIDTH = 128,
    parameter logic [127:0] ROOT_KEY = '0
) (
    input logic clk,
    input logic rst_b,
    doe_cipher_if.cipher cph
);
    import doe_pkg::*;

    localparam int CNT_W = $clog2(CIPHER_ROUNDS + 1);

    logic [SRC_WIDTH-1:0] key_q;
    logic [SRC_WIDTH-1:0] state_q;
    logic [SRC_WIDTH-1:0] round_out;
    logic [DEST_WIDTH-1:0] dest_q;
    logic [CNT_W-1:0] round_cnt;
    logic busy;
    logic ready;
    logic avail;
    logic last_round;

    function automatic logic [SRC_WIDTH-1:0] rotl(input logic [SRC_WIDTH-1:0] v);
        rotl = {v[SRC_WIDTH-1-ROUND_ROT:0], v[SRC_WIDTH-1:SRC_WIDTH-ROUND_ROT]};
    endfunction

    assign round_out = rotl(state_q) ^ key_q;

    // the first round runs on the edge that sees next
    assign last_round = busy && (round_cnt == CNT_W'(CIPHER_ROUNDS - 1));

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            busy <= 1'b0;
            ready <= 1'b0;
            avail <= 1'b0;
            round_cnt <= '0;
        end else if (cph.init) begin
            busy <= 1'b0;
            ready <= 1'b0;
            avail <= 1'b0;
        end else if (cph.next) begin
            busy <= 1'b1;
            ready <= 1'b0;
            avail <= 1'b0;
            round_cnt <= CNT_W'(1);
        end else if (last_round) begin
            busy <= 1'b0;
            ready <= 1'b1;
            avail <= 1'b1;
        end else if (busy) begin
            round_cnt <= round_cnt + 1'b1;
        end else begin
            ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cph.init) begin
            key_q <= ROOT_KEY[SRC_WIDTH-1:0];
        end else if (last_round) begin
            key_q <= round_out;
        end
        if (cph.src_write_en) begin
            state_q <= cph.src_write_data;
        end else if (cph.next || busy) begin
            state_q <= round_out;
        end
        if (last_round) begin
            dest_q <= round_out[DEST_WIDTH-1:0];
        end
    end

    assign cph.init_done = ready;
    assign cph.dest_data_avail = avail;
    assign cph.dest_data = dest_q;

endmodule

// File: hw/doe_fsm.sv
/* deobfuscation flow controller
   runs the obfuscated blocks through the cipher and writes results to the vault */
`timescale 1ns/1ns

module doe_fsm #(
    parameter int SRC_WIDTH = 128,
    parameter int DEST_WIDTH = 128
) (
    input logic clk,
    input logic rst_b,
    input logic hard_rst_b,
    input doe_pkg::doe_cmd_e cur_cmd,
    input logic [doe_pkg::KV_ENTRY_ADDR_W-1:0] cur_dest,
    input logic [doe_pkg::OBF_UDS_DWORDS*32-1:0] obf_uds_seed,
    input logic [doe_pkg::OBF_FE_DWORDS*32-1:0] obf_field_entropy,
    input logic zeroize,
    doe_cipher_if.fsm cph,
    kv_write_if.fsm kv,
    output logic flow_done,
    output logic flow_in_progress,
    output logic lock_uds,
    output logic lock_fe
);
    import doe_pkg::*;

    localparam int DEST_NUM_DWORDS = DEST_WIDTH / 32;
    localparam int DEST_OFFSET_W = $clog2(DEST_NUM_DWORDS);
    localparam int UDS_NUM_BLOCKS = OBF_UDS_DWORDS * 32 / SRC_WIDTH;
    localparam int FE_NUM_BLOCKS = OBF_FE_DWORDS * 32 / SRC_WIDTH;
    localparam int MAX_BLOCKS = (UDS_NUM_BLOCKS > FE_NUM_BLOCKS) ? UDS_NUM_BLOCKS : FE_NUM_BLOCKS;
    localparam int BLOCK_OFFSET_W = $clog2(MAX_BLOCKS);

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        BLOCK,
        NEXT,
        WAIT,
        WRITE,
        DONE
    } doe_fsm_state_e;

    doe_fsm_state_e state_q, state_nxt;

    logic running_uds;
    logic running_fe;
    logic start;
    logic zeroize_hold;
    logic block_done;
    logic write_done;
    logic write_en;
    logic [BLOCK_OFFSET_W-1:0] block_offset, block_offset_nxt;
    logic [KV_OFFSET_W-1:0] wr_offset, wr_offset_nxt;
    logic [KV_ENTRY_ADDR_W-1:0] dest_entry;
    logic [DEST_OFFSET_W-1:0] swz_idx;
    logic [SRC_WIDTH-1:0] src_block;

    assign running_uds = (cur_cmd == DOE_UDS);
    assign running_fe = (cur_cmd == DOE_FE);
    assign flow_in_progress = running_uds || running_fe;

    // a locked flow never leaves IDLE
    assign start = (running_uds && !lock_uds) || (running_fe && !lock_fe);

    assign block_done = running_uds ? (block_offset == BLOCK_OFFSET_W'(UDS_NUM_BLOCKS - 1)) :
                                      (block_offset == BLOCK_OFFSET_W'(FE_NUM_BLOCKS - 1));
    assign write_done = (wr_offset[DEST_OFFSET_W-1:0] == DEST_OFFSET_W'(DEST_NUM_DWORDS - 1));

    // zeroize is a pulse, stretch it until the client issues a fresh command
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            zeroize_hold <= 1'b0;
        end else if (zeroize) begin
            zeroize_hold <= 1'b1;
        end else if (flow_in_progress) begin
            zeroize_hold <= 1'b0;
        end
    end

    always_comb begin
        state_nxt = state_q;
        block_offset_nxt = block_offset;
        wr_offset_nxt = wr_offset;
        cph.init = 1'b0;
        cph.next = 1'b0;
        cph.src_write_en = 1'b0;
        write_en = 1'b0;
        flow_done = 1'b0;

        unique case (state_q)
            IDLE: begin
                if (start) begin
                    state_nxt = INIT;
                end
                flow_done = (running_uds && lock_uds) || (running_fe && lock_fe);
            end
            INIT: begin
                cph.init = 1'b1;
                state_nxt = WAIT;
            end
            BLOCK: begin
                cph.src_write_en = 1'b1;
                state_nxt = NEXT;
            end
            NEXT: begin
                cph.next = 1'b1;
                state_nxt = WAIT;
            end
            WAIT: begin
                // after init there is no result yet, so go fetch the first block
                if (cph.init_done && cph.dest_data_avail) begin
                    state_nxt = WRITE;
                end else if (cph.init_done) begin
                    state_nxt = BLOCK;
                end
            end
            WRITE: begin
                write_en = 1'b1;
                wr_offset_nxt = wr_offset + 1'b1;
                if (write_done && block_done) begin
                    state_nxt = DONE;
                end else if (write_done) begin
                    state_nxt = BLOCK;
                    block_offset_nxt = block_offset + 1'b1;
                end
            end
            DONE: begin
                flow_done = 1'b1;
                block_offset_nxt = '0;
                wr_offset_nxt = '0;
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state_q <= IDLE;
            block_offset <= '0;
            wr_offset <= '0;
        end else if (zeroize || zeroize_hold) begin
            state_q <= IDLE;
            block_offset <= '0;
            wr_offset <= '0;
        end else begin
            state_q <= state_nxt;
            block_offset <= block_offset_nxt;
            wr_offset <= wr_offset_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start) begin
            dest_entry <= cur_dest;
        end
    end

    always_comb begin
        if (running_uds) begin
            src_block = obf_uds_seed[block_offset*SRC_WIDTH +: SRC_WIDTH];
        end else if (running_fe) begin
            src_block = obf_field_entropy[block_offset*SRC_WIDTH +: SRC_WIDTH];
        end else begin
            src_block = '0;
        end
    end

    assign cph.src_write_data = src_block;

    // the cipher result is big endian, so its top dword goes to the lowest offset
    assign swz_idx = DEST_OFFSET_W'(DEST_NUM_DWORDS - 1) - wr_offset[DEST_OFFSET_W-1:0];

    assign kv.write_en = write_en;
    assign kv.write_entry = dest_entry;
    assign kv.write_offset = wr_offset;
    assign kv.write_data = write_en ? cph.dest_data[swz_idx*32 +: 32] : '0;

    // a completed flow stays locked until the next hard reset
    always_ff @(posedge clk or negedge hard_rst_b) begin
        if (!hard_rst_b) begin
            lock_uds <= 1'b0;
            lock_fe <= 1'b0;
        end else begin
            if (running_uds && flow_done) begin
                lock_uds <= 1'b1;
            end
            if (running_fe && flow_done) begin
                lock_fe <= 1'b1;
            end
        end
    end

endmodule

// File: hw/doe_cmd_reg.sv
/* client command register
   holds one command and its vault entry until the flow ends or zeroize */
`timescale 1ns/1ns

module doe_cmd_reg (
    input logic clk,
    input logic rst_b,
    input logic cmd_valid,
    input doe_pkg::doe_cmd_e cmd,
    input logic [doe_pkg::KV_ENTRY_ADDR_W-1:0] dest_sel,
    input logic flow_done,
    input logic zeroize,
    output doe_pkg::doe_cmd_e cur_cmd,
    output logic [doe_pkg::KV_ENTRY_ADDR_W-1:0] cur_dest
);
    import doe_pkg::*;

    logic accept;

    // a new command only lands while nothing is held
    assign accept = cmd_valid && (cur_cmd == DOE_IDLE_CMD);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            cur_cmd <= DOE_IDLE_CMD;
            cur_dest <= '0;
        end else if (flow_done || zeroize) begin
            // end of flow wins over a command arriving in the same cycle
            cur_cmd <= DOE_IDLE_CMD;
        end else if (accept) begin
            cur_cmd <= cmd;
            cur_dest <= dest_sel;
        end
    end

endmodule

// File: hw/doe_if.sv
/* key vault write interface and block cipher interface */
`timescale 1ns/1ns

interface kv_write_if;
    import doe_pkg::*;

    logic write_en;
    logic [KV_ENTRY_ADDR_W-1:0] write_entry;
    logic [KV_OFFSET_W-1:0] write_offset;
    logic [31:0] write_data;

    modport fsm (
        output write_en, write_entry, write_offset, write_data
    );

    modport vault (
        input write_en, write_entry, write_offset, write_data
    );
endinterface

interface doe_cipher_if #(
    parameter int SRC_WIDTH = 128,
    parameter int DEST_WIDTH = 128
);
    logic src_write_en;
    logic [SRC_WIDTH-1:0] src_write_data;
    logic init;
    logic next;
    logic init_done;
    logic dest_data_avail;
    logic [DEST_WIDTH-1:0] dest_data;

    modport fsm (
        output src_write_en, src_write_data, init, next,
        input init_done, dest_data_avail, dest_data
    );

    modport cipher (
        input src_write_en, src_write_data, init, next,
        output init_done, dest_data_avail, dest_data
    );
endinterface

// File: hw/doe_pkg.sv
/* deobfuscation engine package
   commands, key vault geometry and cipher round constants */
`include "doe_defines.svh"

package doe_pkg;

    // obfuscated secret sizes
    parameter int OBF_UDS_DWORDS = `OBF_UDS_DWORDS;
    parameter int OBF_FE_DWORDS = `OBF_FE_DWORDS;

    // client commands
    typedef enum logic [1:0] {
        DOE_IDLE_CMD = 2'b00,
        DOE_UDS = 2'b01,
        DOE_FE = 2'b10
    } doe_cmd_e;

    // key vault geometry
    parameter int KV_NUM_ENTRIES = 8;
    parameter int KV_ENTRY_ADDR_W = 3;
    parameter int KV_ENTRY_DWORDS = 16;
    parameter int KV_OFFSET_W = 4;

    // the cipher does this many rotate-and-xor rounds per block
    parameter int CIPHER_ROUNDS = 4;
    parameter int ROUND_ROT = 7;

endpackage

// File: include/doe_defines.svh
/* deobfuscation engine secret sizes, in dwords */
`ifndef DOE_DEFINES_SVH
`define DOE_DEFINES_SVH

`define OBF_UDS_DWORDS 16
`define OBF_FE_DWORDS 8

`endif
